/* flist.f */
cft_bus_pkg.sv
bus_addr_reg.sv
bus_mbu.sv
bus_ibus_read.sv
bus_databus.sv
card_bus.sv
tb_card_bus_sva.sv
tb_card_bus.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the card_bus testbench with Verilator and run it
# Success is decided by the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_card_bus \
   && ./obj_dir/Vtb_card_bus +verilator+error+limit+100 \
      | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
   && echo "Simulation run succeeded" \
   || { echo "Simulation run did not succeed"; exit 1; }

/* tb_card_bus.sv */
/* Directed testbench for the CFT bus board
   Reset, AR load, bank registers, I/O decode, constant store and wait-states */

`timescale 1ns/100ps
`default_nettype none

module tb_card_bus
   import cft_bus_pkg::*;
;

   localparam int MAX_CYCLES = 2000;     // Six tests plus margin

   logic clk3, arst_n, nmem, nio, nr, nwen, nws, nhalt, idxen;
   ucode_addr_t raddr, waddr;
   word_t ibus_in, ibus_out, db_out;
   logic [BANK_IDX_W-1:0] ir_idx;
   addr_t ab;
   logic ibus_oe, db_oe, nw, nsysdev, niodev1xx, niodev2xx, niodev3xx;

   bank_t bank_model [NUM_BANKS];        // Expected bank registers
   word_t const_table [MAX_CONSTS] = '{16'h0000, 16'h0001, 16'h0002, 16'h0004,
                                       16'h0008, 16'h00FF, 16'hFF00, 16'hFFFF};
   int    errors = 0;
   int    checks = 0;
   int    tests = 0;
   int    test_err0;                     // Error count at test start
   int    cycle_count = 0;

   card_bus #(.NUM_CONSTS(8)) DUT (.*);

   always #4 clk3 = ~clk3;               // 8 ns period

   // Watchdog
   always @(posedge clk3) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: run exceeded %0d clock cycles", MAX_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      checks++;
      if (got !== exp) begin
         $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bank(input string name, input bank_t got, input bank_t exp);
      checks++;
      if (got !== exp) begin
         $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         $display("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic start_test();
      test_err0 = errors;
      tests++;
   endtask

   task automatic finish_test(input string name);
      $display("%-14s %s (%0d errors)", name,
               (errors == test_err0) ? "ok" : "failing", errors - test_err0);
   endtask

   //////////////////////////////
   // Bus helpers
   //////////////////////////////

   task automatic apply_reset();
      @(posedge clk3);
      arst_n <= 1'b0;
      repeat (3) @(posedge clk3);
      arst_n <= 1'b1;
      foreach (bank_model[i]) bank_model[i] = '0;   // Banks clear on reset
      @(negedge clk3);
   endtask

   // AR captured at the second edge and checked at the following negedge
   task automatic load_ar(input word_t w);
      @(posedge clk3);
      waddr   <= WADDR_AR;
      ibus_in <= w;
      @(posedge clk3);
      waddr   <= 5'h00;
      @(negedge clk3);
   endtask

   task automatic write_cycle(input word_t data, input logic io, input int waits,
                              output int low_cycles);
      int left;
      left       = waits;
      low_cycles = 0;
      @(posedge clk3);
      nwen    <= 1'b0;
      nr      <= 1'b1;
      nio     <= !io;
      nmem    <= io;
      ibus_in <= data;
      nws     <= 1'b1;
      @(posedge clk3);                   // Start edge
      nws <= (left > 0) ? 1'b0 : 1'b1;
      if (left > 0) left--;
      @(negedge clk3);
      check_word("db_out", db_out, data);
      check_bit("db_oe", db_oe, 1'b1);
      while (!nw && low_cycles < 20) begin
         low_cycles++;
         @(posedge clk3);
         nws <= (left > 0) ? 1'b0 : 1'b1;   // One low sample per wait cycle
         if (left > 0) left--;
         @(negedge clk3);
      end
      @(posedge clk3);
      nwen <= 1'b1;                      // Rearm the driver
      nws  <= 1'b1;
      nio  <= 1'b1;
      nmem <= 1'b1;
      @(posedge clk3);
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic test_reset();
      start_test();
      check_bit("nw", nw, 1'b1);
      check_bit("db_oe", db_oe, 1'b0);
      check_addr("ab", ab, '0);
      check_bit("nsysdev", nsysdev, 1'b1);
      check_bit("niodev1xx", niodev1xx, 1'b1);
      check_bit("niodev2xx", niodev2xx, 1'b1);
      check_bit("niodev3xx", niodev3xx, 1'b1);
      finish_test("reset");
   endtask

   task automatic test_ar_load();
      word_t w;
      start_test();
      @(posedge clk3);
      idxen <= 1'b0;
      raddr <= RADDR_AR;
      repeat (8) begin
         w = word_t'($urandom);
         load_ar(w);
         check_addr("ab", ab, {bank_model[0], w});
         check_word("ibus_out", ibus_out, w);
         check_bit("ibus_oe", ibus_oe, 1'b1);
      end
      finish_test("ar_load");
   endtask

   task automatic test_bank_writes();
      int    idx;
      int    k;
      int    lc;
      word_t data;
      word_t w;
      start_test();
      // Bank 0 last since it extends the I/O address of the others
      for (int n = 1; n <= NUM_BANKS; n++) begin
         idx  = n % NUM_BANKS;
         data = word_t'($urandom);
         load_ar(word_t'(8 + idx));
         check_addr("ab", ab, {bank_model[0], word_t'(8 + idx)});
         write_cycle(data, 1'b1, 0, lc);
         bank_model[idx] = data[BANK_W-1:0];
      end
      @(posedge clk3);
      idxen <= 1'b1;
      raddr <= RADDR_MBP;
      for (int i = 0; i < NUM_BANKS; i++) begin
         @(posedge clk3);
         ir_idx <= 3'(i);
         @(negedge clk3);
         check_word("ibus_out", ibus_out, {8'h00, bank_model[i]});
         check_bit("ibus_oe", ibus_oe, 1'b1);
      end
      k = int'($urandom % NUM_BANKS);
      w = word_t'($urandom);
      @(posedge clk3);
      ir_idx <= 3'(k);
      load_ar(w);
      check_bank("ab[23:16]", ab[ADDR_W-1:WORD_W], bank_model[k]);
      check_word("ab[15:0]", ab[WORD_W-1:0], w);
      @(posedge clk3);
      idxen <= 1'b0;
      finish_test("bank_writes");
   endtask

   task automatic test_io_decode();
      word_t addrs [6] = '{16'h0012, 16'h01A5, 16'h02FF, 16'h0300, 16'h0400, 16'h8100};
      logic  io;
      logic [1:0] page;
      start_test();
      // First pass with bank 0 still set, second with the banks cleared
      for (int pass = 0; pass < 2; pass++) begin
         foreach (addrs[a]) begin
            load_ar(addrs[a]);
            for (int n = 0; n < 2; n++) begin
               @(posedge clk3);
               nio <= 1'(n);
               @(negedge clk3);
               io   = (n == 0) && (bank_model[0] == '0) && (addrs[a][15:10] == '0);
               page = addrs[a][9:8];
               check_bit("nsysdev", nsysdev, !(io && page == 2'd0));
               check_bit("niodev1xx", niodev1xx, !(io && page == 2'd1));
               check_bit("niodev2xx", niodev2xx, !(io && page == 2'd2));
               check_bit("niodev3xx", niodev3xx, !(io && page == 2'd3));
            end
         end
         if (pass == 0) begin
            apply_reset();
         end
      end
      finish_test("io_decode");
   endtask

   task automatic test_constants();
      ucode_addr_t others [3] = '{5'h00, 5'h10, 5'h17};
      start_test();
      for (int c = 0; c < MAX_CONSTS; c++) begin
         @(posedge clk3);
         raddr <= ucode_addr_t'(RADDR_CONST_BASE + c);
         @(negedge clk3);
         check_word("ibus_out", ibus_out, const_table[c]);
         check_bit("ibus_oe", ibus_oe, 1'b1);
      end
      foreach (others[o]) begin
         @(posedge clk3);
         raddr <= others[o];
         @(negedge clk3);
         check_bit("ibus_oe", ibus_oe, 1'b0);   // Not a board code
      end
      finish_test("constants");
   endtask

   task automatic test_wait_states();
      int    waits;
      int    lc;
      word_t data;
      start_test();
      repeat (8) begin
         waits = int'($urandom % 6);
         data  = word_t'($urandom);
         write_cycle(data, 1'b0, waits, lc);
         check_word("nw low cycles", word_t'(lc), word_t'(1 + waits));
      end
      @(posedge clk3);
      nhalt <= 1'b0;                     // Halted so no cycle may start
      nwen  <= 1'b0;
      nmem  <= 1'b0;
      repeat (4) begin
         @(negedge clk3);
         check_bit("nw", nw, 1'b1);
      end
      @(posedge clk3);
      nwen  <= 1'b1;
      nhalt <= 1'b1;
      nmem  <= 1'b1;
      finish_test("wait_states");
   endtask

   initial begin
      int total;
      clk3 = 1'b0;
      arst_n = 1'b0;
      nmem = 1'b1;
      nio = 1'b1;
      nr = 1'b1;
      nwen = 1'b1;
      nws = 1'b1;
      nhalt = 1'b1;
      raddr = 5'h00;
      waddr = 5'h00;
      ibus_in = '0;
      ir_idx = '0;
      idxen = 1'b0;
      void'($urandom(32'h2bda84fe));     // Seed once
      apply_reset();
      test_reset();
      test_ar_load();
      test_bank_writes();
      test_io_decode();
      test_constants();
      test_wait_states();
      total = errors + DUT.u_databus.u_sva.sva_errors;
      $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
               tests, checks, errors, DUT.u_databus.u_sva.sva_errors);
      if (total == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb_card_bus_sva.sv */
/* Bus strobe assertions for the data bus driver
   Bound into bus_databus; checks strobe, drive enable and reset behavior */

`timescale 1ns/100ps
`default_nettype none

module tb_card_bus_sva (
   input wire logic clk3,                // Board clock
   input wire logic arst_n,              // Async reset
   input wire logic nws,                 // Wait-state request
   input wire logic nw,                  // Write strobe
   input wire logic db_oe                // Data bus drive enable
);

   int sva_errors = 0;                   // Read by the testbench summary

   // Strobe and drive window always coincide
   assert property (@(posedge clk3) disable iff (!arst_n) nw == !db_oe)
      else begin
         $error("nw and db_oe disagree");
         sva_errors++;
      end

   // Wait-state holds the strobe low
   assert property (@(posedge clk3) disable iff (!arst_n) (!nw && !nws) |=> !nw)
      else begin
         $error("nw released while nws was low");
         sva_errors++;
      end

   // No strobe while in reset
   assert property (@(posedge clk3) !arst_n |-> nw)
      else begin
         $error("nw low during reset");
         sva_errors++;
      end

endmodule

bind bus_databus tb_card_bus_sva u_sva (
   .clk3   (clk3),
   .arst_n (arst_n),
   .nws    (nws),
   .nw     (nw),
   .db_oe  (db_oe)
);

`default_nettype wire

/* card_bus.sv */
/* CFT bus board top level
   Address register, banking unit, ibus readback and data bus driver */

`timescale 1ns/100ps
`default_nettype none

module card_bus
   import cft_bus_pkg::*;
#(
   parameter int NUM_CONSTS = 8                    // Constant store depth
) (
   input  wire logic                  clk3,        // Single board clock
   input  wire logic                  arst_n,      // Async reset

   // Bus transaction levels
   input  wire logic                  nmem,        // Memory space
   input  wire logic                  nio,         // I/O space
   input  wire logic                  nr,          // Read
   input  wire logic                  nwen,        // Write enable, control unit
   input  wire logic                  nws,         // Wait-state request
   input  wire logic                  nhalt,       // Halt

   // Microcode fields and processor bus
   input  wire ucode_addr_t           raddr,       // ibus read address
   input  wire ucode_addr_t           waddr,       // ibus write address
   input  wire word_t                 ibus_in,     // Processor drives ibus
   input  wire logic [BANK_IDX_W-1:0] ir_idx,      // IR[2:0]
   input  wire logic                  idxen,       // Auto-index enable

   // Address and data buses
   output      addr_t                 ab,          // Address bus, equals AR
   output      word_t                 ibus_out,    // Board's ibus read value
   output      logic                  ibus_oe,     // ibus driven by board
   output      word_t                 db_out,      // Data bus write value
   output      logic                  db_oe,       // Data bus driven
   output      logic                  nw,          // Write strobe

   // I/O device selects
   output      logic                  nsysdev,     // I/O 000-0FF
   output      logic                  niodev1xx,   // I/O 100-1FF
   output      logic                  niodev2xx,   // I/O 200-2FF
   output      logic                  niodev3xx    // I/O 300-3FF
);

   bank_t aext;                                    // MBU to AR[23:16]

   //////////////////////////////
   // Address register
   //////////////////////////////

   bus_addr_reg u_addr_reg (
      .clk3      (clk3),
      .arst_n    (arst_n),
      .waddr     (waddr),
      .ibus_in   (ibus_in),
      .aext      (aext),
      .nio       (nio),
      .ab        (ab),
      .nsysdev   (nsysdev),
      .niodev1xx (niodev1xx),
      .niodev2xx (niodev2xx),
      .niodev3xx (niodev3xx)
   );

   //////////////////////////////
   // Memory banking unit
   //////////////////////////////

   bus_mbu u_mbu (
      .clk3    (clk3),
      .arst_n  (arst_n),
      .ir_idx  (ir_idx),
      .idxen   (idxen),
      .ab      (ab),
      .nsysdev (nsysdev),
      .nw      (nw),
      .db_out  (db_out),
      .aext    (aext)
   );

   bus_ibus_read #(
      .NUM_CONSTS (NUM_CONSTS)
   ) u_ibus_read (
      .raddr    (raddr),
      .ab       (ab),
      .aext     (aext),
      .ibus_out (ibus_out),
      .ibus_oe  (ibus_oe)
   );

   bus_databus u_databus (
      .clk3    (clk3),
      .arst_n  (arst_n),
      .nmem    (nmem),
      .nio     (nio),
      .nr      (nr),
      .nwen    (nwen),
      .nws     (nws),
      .nhalt   (nhalt),
      .ibus_in (ibus_in),
      .nw      (nw),
      .db_out  (db_out),
      .db_oe   (db_oe)
   );

endmodule

`default_nettype wire

/* bus_databus.sv */
/* Data bus write driver
   Latches ibus and strobes nw for one cycle plus any wait-states */

`timescale 1ns/100ps
`default_nettype none

module bus_databus
   import cft_bus_pkg::*;
(
   input  wire logic  clk3,              // Board clock
   input  wire logic  arst_n,            // Async reset
   input  wire logic  nmem,              // Memory space
   input  wire logic  nio,               // I/O space
   input  wire logic  nr,                // Read
   input  wire logic  nwen,              // Write enable from control unit
   input  wire logic  nws,               // Wait-state request
   input  wire logic  nhalt,             // Halt blocks new cycles
   input  wire word_t ibus_in,           // Write data source
   output      logic  nw,                // Write strobe
   output      word_t db_out,            // Latched write data
   output      logic  db_oe              // Data bus drive enable
);

   typedef enum logic [1:0] {
      S_IDLE,                            // Waiting for a write
      S_STROBE,                          // nw low, db driven
      S_WAIT_REL                         // Wait for nwen to drop away
   } state_t;

   state_t state_q;
   state_t state_d;
   logic   start;                        // Write cycle begins this edge

   //////////////////////////////
   // Cycle control
   //////////////////////////////

   assign start = (state_q == S_IDLE) && !nwen && nr && (!nmem || !nio) && nhalt;

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: begin
            if (start) state_d = S_STROBE;
         end
         S_STROBE: begin
            if (nws) state_d = S_WAIT_REL;   // No wait-state, release
         end
         S_WAIT_REL: begin
            if (nwen) state_d = S_IDLE;      // Rearm once nwen is high
         end
         default: state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= S_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Data latch
   always_ff @(posedge clk3) begin
      if (start) begin
         db_out <= ibus_in;              // Capture at cycle start
      end
   end

   assign db_oe = (state_q == S_STROBE);
   assign nw    = !db_oe;                // Strobe tracks the drive window

endmodule

`default_nettype wire

/* bus_ibus_read.sv */
/* ibus read multiplexer
   AR readback, bank readback and the constant store ROM */

`timescale 1ns/100ps
`default_nettype none

module bus_ibus_read
   import cft_bus_pkg::*;
#(
   parameter int NUM_CONSTS = 8                  // Owned codes from 5'h18
) (
   input  wire ucode_addr_t raddr,               // ibus read address
   input  wire addr_t       ab,                  // Address register value
   input  wire bank_t       aext,                // Selected bank
   output      word_t       ibus_out,            // Read value
   output      logic        ibus_oe              // Board owns this code
);

   localparam int CIDX_W = $clog2(MAX_CONSTS);

   ucode_addr_t const_off;                       // Code minus the ROM base
   logic        const_hit;                       // Code inside the ROM range

   // Constant ROM contents
   function automatic word_t const_rom(input logic [CIDX_W-1:0] idx);
      case (idx)
         3'd0:    return 16'h0000;
         3'd1:    return 16'h0001;
         3'd2:    return 16'h0002;
         3'd3:    return 16'h0004;
         3'd4:    return 16'h0008;
         3'd5:    return 16'h00FF;       // Byte mask
         3'd6:    return 16'hFF00;
         default: return 16'hFFFF;       // All ones
      endcase
   endfunction

   assign const_off = raddr - RADDR_CONST_BASE;
   assign const_hit = (raddr >= RADDR_CONST_BASE) && (const_off < UADDR_W'(NUM_CONSTS));

   always_comb begin
      ibus_out = '0;
      ibus_oe  = 1'b0;
      if (raddr == RADDR_AR) begin
         ibus_out = ab[WORD_W-1:0];      // AR low word
         ibus_oe  = 1'b1;
      end else if (raddr == RADDR_MBP) begin
         ibus_out = {{(WORD_W-BANK_W){1'b0}}, aext};
         ibus_oe  = 1'b1;
      end else if (const_hit) begin
         ibus_out = const_rom(const_off[CIDX_W-1:0]);
         ibus_oe  = 1'b1;
      end
   end

endmodule

`default_nettype wire

/* bus_mbu.sv */
/* Memory banking unit
   Eight bank registers written through I/O space; one extends the address */

`timescale 1ns/100ps
`default_nettype none

module bus_mbu
   import cft_bus_pkg::*;
(
   input  wire logic                  clk3,      // Board clock
   input  wire logic                  arst_n,    // Async reset
   input  wire logic [BANK_IDX_W-1:0] ir_idx,    // IR[2:0] bank index
   input  wire logic                  idxen,     // Auto-index enable
   input  wire addr_t                 ab,        // Address bus
   input  wire logic                  nsysdev,   // I/O page 0 select
   input  wire logic                  nw,        // Write strobe
   input  wire word_t                 db_out,    // Data bus write value
   output      bank_t                 aext       // Address extension
);

   bank_t                 bank_q [NUM_BANKS];    // MBP0-MBP7
   logic                  bank_we;               // I/O write hits the MBU
   logic [BANK_IDX_W-1:0] wr_idx;                // Register being written
   logic [BANK_IDX_W-1:0] rd_idx;                // Register feeding AEXT

   //////////////////////////////
   // I/O write decode
   //////////////////////////////

   // Offsets 08-0F in page 0, qualified by the write strobe
   assign bank_we = !nsysdev && !nw &&
                    (ab[BANK_W-1:MBU_IO_SEL_LSB] == MBU_IO_BASE[BANK_W-1:MBU_IO_SEL_LSB]);
   assign wr_idx  = ab[BANK_IDX_W-1:0];

   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_BANKS; i++) begin
            bank_q[i] <= '0;             // All banks to zero
         end
      end else if (bank_we) begin
         bank_q[wr_idx] <= db_out[BANK_W-1:0];   // Low byte of the data bus
      end
   end

   //////////////////////////////
   // Bank selection
   //////////////////////////////

   // Auto-index uses IR[2:0], otherwise MBP0
   assign rd_idx = idxen ? ir_idx : '0;
   assign aext   = bank_q[rd_idx];

endmodule

`default_nettype wire

/* bus_addr_reg.sv */
/* Address register with I/O device-select decoder
   AR loads AEXT and ibus together; selects decode the four I/O pages */

`timescale 1ns/100ps
`default_nettype none

module bus_addr_reg
   import cft_bus_pkg::*;
(
   input  wire logic        clk3,        // Board clock
   input  wire logic        arst_n,      // Async reset
   input  wire ucode_addr_t waddr,       // ibus write address
   input  wire word_t       ibus_in,     // Low word source
   input  wire bank_t       aext,        // Top byte source, from MBU
   input  wire logic        nio,         // I/O space
   output      addr_t       ab,          // Address bus
   output      logic        nsysdev,     // Page 0 select
   output      logic        niodev1xx,   // Page 1 select
   output      logic        niodev2xx,   // Page 2 select
   output      logic        niodev3xx    // Page 3 select
);

   addr_t      ar_q;                     // The address register
   logic       io_space;                 // I/O cycle inside 000-3FF
   logic [1:0] io_page;                  // ab[9:8]

   //////////////////////////////
   // AR load
   //////////////////////////////

   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n) begin
         ar_q <= '0;
      end else if (waddr == WADDR_AR) begin
         ar_q <= {aext, ibus_in};        // Bank byte plus 16-bit word
      end
   end

   assign ab = ar_q;

   //////////////////////////////
   // I/O decode
   //////////////////////////////

   assign io_space = !nio && (ar_q[ADDR_W-1:IO_SPACE_LSB] == '0);
   assign io_page  = ar_q[IO_PAGE_LSB+1:IO_PAGE_LSB];

   // One select low at a time, all high outside I/O space
   always_comb begin
      nsysdev   = 1'b1;
      niodev1xx = 1'b1;
      niodev2xx = 1'b1;
      niodev3xx = 1'b1;
      if (io_space) begin
         case (io_page)
            IO_PAGE_SYS: nsysdev   = 1'b0;   // Board-level devices
            IO_PAGE_1XX: niodev1xx = 1'b0;
            IO_PAGE_2XX: niodev2xx = 1'b0;
            IO_PAGE_3XX: niodev3xx = 1'b0;
            default:     nsysdev   = 1'b1;
         endcase
      end
   end

endmodule

`default_nettype wire

/* cft_bus_pkg.sv */
/* CFT bus board shared definitions
   Bus widths, ibus microcode codes and I/O space decode constants */

`default_nettype none

package cft_bus_pkg;

   //////////////////////////////
   // Widths and types
   //////////////////////////////

   localparam int WORD_W     = 16;                  // ibus and data bus
   localparam int ADDR_W     = 24;                  // Address bus
   localparam int BANK_W     = 8;                   // AEXT, top byte of AR
   localparam int UADDR_W    = 5;                   // raddr/waddr fields
   localparam int NUM_BANKS  = 8;                   // MBU bank registers
   localparam int BANK_IDX_W = $clog2(NUM_BANKS);   // IR[2:0] width

   typedef logic [WORD_W-1:0]  word_t;
   typedef logic [ADDR_W-1:0]  addr_t;
   typedef logic [BANK_W-1:0]  bank_t;
   typedef logic [UADDR_W-1:0] ucode_addr_t;

   //////////////////////////////
   // ibus microcode codes
   //////////////////////////////

   localparam ucode_addr_t WADDR_AR         = 5'h02;   // Write AR
   localparam ucode_addr_t RADDR_AR         = 5'h02;   // Read AR[15:0]
   localparam ucode_addr_t RADDR_MBP        = 5'h03;   // Read current bank
   localparam ucode_addr_t RADDR_CONST_BASE = 5'h18;   // Constant store 18-1F
   localparam int          MAX_CONSTS       = 8;       // Size of the ROM table

   //////////////////////////////
   // I/O space decode
   //////////////////////////////

   localparam int          IO_SPACE_LSB = 10;      // ab[23:10] zero for I/O
   localparam int          IO_PAGE_LSB  = 8;       // ab[9:8] picks the page
   localparam logic [1:0]  IO_PAGE_SYS  = 2'd0;    // 000-0FF
   localparam logic [1:0]  IO_PAGE_1XX  = 2'd1;    // 100-1FF
   localparam logic [1:0]  IO_PAGE_2XX  = 2'd2;    // 200-2FF
   localparam logic [1:0]  IO_PAGE_3XX  = 2'd3;    // 300-3FF

   localparam bank_t       MBU_IO_BASE    = 8'h08; // Bank regs at 08-0F
   localparam int          MBU_IO_SEL_LSB = 3;     // ab[7:3] matches base

endpackage

`default_nettype wire
